//--- Makefile
# Verilator flow for the two-channel capture buffer

VERILATOR  ?= verilator
TB_TOP     ?= tbCaptureTop
RTL_TOP    ?= captureTop
FILELIST   ?= captureTop.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# the testbench reads captureGolden.txt relative to this directory
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- captureGolden.txt
# all numbers hex: W ch value | B ch count first | I | F ch | R addr expected
# B runs in the background, I waits for bursts and both oIdle
# single writes, then read back at ch*20 + index
W 0 1001
W 0 1002
W 1 2001
W 1 2002
W 0 1003
I
R 00 1001
R 01 1002
R 02 1003
R 20 2001
R 21 2002
# interleaved bursts, ch0 fills its half up to offset 1F
B 0 1D 3000
B 1 8 4000
I
R 03 3000
R 0F 300C
R 1F 301C
R 22 4000
R 29 4007
# 40 writes on ch0, samples 20..27 wrap onto offsets 0..7
B 0 28 5000
I
F 0
R 00 5020
R 07 5027
R 08 5008
R 1F 501F
# host reads of committed ch0 data while ch1 bursts
B 1 18 6000
R 00 5020
R 14 5014
R 05 5025
R 10 5010
I
R 2A 6000
R 3F 6015
R 20 6016
R 21 6017
R 22 4000

//--- capturePkg.sv
package capturePkg;

	// ----------------------------------------
	// widths and depths
	// ----------------------------------------
	localparam int SAMPLE_W    = 16;
	localparam int FIFO_DEPTH  = 16;
	localparam int FIFO_AW     = 4;
	// free slots left when full rises
	localparam int ALMOST_FULL = 2;
	localparam int RAM_DEPTH   = 64;
	localparam int RAM_AW      = 6;
	// offset inside one channel half
	localparam int REGION_AW   = 5;
	// two drain engines plus host
	localparam int NUM_PEERS   = 3;

	typedef logic [SAMPLE_W-1:0]  sample_t;
	typedef logic [FIFO_AW-1:0]   fifoAddr_t;
	typedef logic [RAM_AW-1:0]    ramAddr_t;
	typedef logic [REGION_AW-1:0] regionOff_t;

	// ----------------------------------------
	// peer request and response
	// ----------------------------------------
	typedef struct packed {
		ramAddr_t addr;
		sample_t  wdata;
		logic     write;
	} ramReq_t;

	typedef struct packed {
		logic    ack;
		sample_t rdata;
	} ramRsp_t;

	// drain engine FSM
	typedef enum logic [2:0] {IDLE, POP, WAIT_DATA, REQ, RELEASE} drainState_t;

	// arbiter FSM
	typedef enum logic [1:0] {FREE, ACCESS, HOLD, DROP} arbState_t;

endpackage

//--- captureTop.f
capturePkg.sv
fifoMem.sv
fifoController.sv
drainEngine.sv
ramArbiter.sv
sharedRam.sv
captureTop.sv
tbCaptureTop.sv

//--- captureTop.sv
module captureTop
	import capturePkg::*;
(
	input  logic     iCLK,
	input  logic     iRST,
	input  logic     iWrEn0,
	input  sample_t  iWrData0,
	output logic     oFull0,
	output logic     oIdle0,
	input  logic     iWrEn1,
	input  sample_t  iWrData1,
	output logic     oFull1,
	output logic     oIdle1,
	input  logic     hostReq,
	input  ramAddr_t hostAddr,
	output logic     hostAck,
	output sample_t  hostRData
);

	// per-channel fifo to engine wires
	logic [1:0]           rdEn;
	logic [1:0]           rdValid;
	logic [1:0]           fifoEmpty;
	logic [1:0]           engIdle;
	sample_t              rdData [2];
	// arbiter peers, 0 and 1 engines, 2 host
	logic [NUM_PEERS-1:0] peerValid;
	ramReq_t              peerReq [NUM_PEERS];
	ramRsp_t              peerRsp [NUM_PEERS];
	// RAM port
	logic                 ramEn;
	logic                 ramWe;
	ramAddr_t             ramAddr;
	sample_t              ramWData;
	sample_t              ramRData;

	// ----------------------------------------
	// channel 0
	// ----------------------------------------
	fifoController uFifo0 (
		.iCLK (iCLK), .iRST (iRST),
		.iWrEn (iWrEn0), .iWrData (iWrData0), .oFull (oFull0),
		.iRdEn (rdEn[0]), .oRdData (rdData[0]),
		.oRdValid (rdValid[0]), .oEmpty (fifoEmpty[0])
	);

	drainEngine uDrain0 (
		.iCLK (iCLK), .iRST (iRST),
		.iEmpty (fifoEmpty[0]), .oRdEn (rdEn[0]),
		.iRdData (rdData[0]), .iRdValid (rdValid[0]), .iChannel (1'b0),
		.oReq (peerReq[0]), .oReqValid (peerValid[0]),
		.iRsp (peerRsp[0]), .oIdle (engIdle[0])
	);

	// ----------------------------------------
	// channel 1
	// ----------------------------------------
	fifoController uFifo1 (
		.iCLK (iCLK), .iRST (iRST),
		.iWrEn (iWrEn1), .iWrData (iWrData1), .oFull (oFull1),
		.iRdEn (rdEn[1]), .oRdData (rdData[1]),
		.oRdValid (rdValid[1]), .oEmpty (fifoEmpty[1])
	);

	drainEngine uDrain1 (
		.iCLK (iCLK), .iRST (iRST),
		.iEmpty (fifoEmpty[1]), .oRdEn (rdEn[1]),
		.iRdData (rdData[1]), .iRdValid (rdValid[1]), .iChannel (1'b1),
		.oReq (peerReq[1]), .oReqValid (peerValid[1]),
		.iRsp (peerRsp[1]), .oIdle (engIdle[1])
	);

	// idle means nothing buffered and nothing in flight
	assign oIdle0 = fifoEmpty[0] & engIdle[0];
	assign oIdle1 = fifoEmpty[1] & engIdle[1];

	// host port, read only
	assign peerValid[2]     = hostReq;
	assign peerReq[2].addr  = hostAddr;
	assign peerReq[2].wdata = '0;
	assign peerReq[2].write = 1'b0;
	assign hostAck          = peerRsp[2].ack;
	assign hostRData        = peerRsp[2].rdata;

	// ----------------------------------------
	// shared RAM and its arbiter
	// ----------------------------------------
	ramArbiter uArb (
		.iCLK (iCLK), .iRST (iRST),
		.iReqValid (peerValid), .iReq (peerReq), .oRsp (peerRsp),
		.oRamEn (ramEn), .oRamWe (ramWe), .oRamAddr (ramAddr),
		.oRamWData (ramWData), .iRamRData (ramRData)
	);

	sharedRam uRam (
		.iCLK (iCLK), .iEn (ramEn), .iWe (ramWe),
		.iAddr (ramAddr), .iWData (ramWData), .oRData (ramRData)
	);

endmodule

//--- drainEngine.sv
module drainEngine
	import capturePkg::*;
(
	input  logic    iCLK,
	input  logic    iRST,
	input  logic    iEmpty,
	output logic    oRdEn,
	input  sample_t iRdData,
	input  logic    iRdValid,
	input  logic    iChannel,
	output ramReq_t oReq,
	output logic    oReqValid,
	input  ramRsp_t iRsp,
	output logic    oIdle
);

	drainState_t state;
	// wrapping write offset inside this channel's half
	regionOff_t  offset;
	// popped sample waiting for the RAM
	sample_t     sample;

	// ----------------------------------------
	// FSM
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state  <= IDLE;
			offset <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (!iEmpty)
						state <= POP;
				end
				// one-cycle pop pulse
				POP:
				begin
					state <= WAIT_DATA;
				end
				// fifo answers two cycles after the pop
				WAIT_DATA:
				begin
					if (iRdValid)
						state <= REQ;
				end
				// hold req until the arbiter acks
				REQ:
				begin
					if (iRsp.ack)
						state <= RELEASE;
				end
				// req low, wait for ack to fall
				RELEASE:
				begin
					if (!iRsp.ack)
					begin
						state  <= IDLE;
						offset <= offset + regionOff_t'(1);
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// sample latch
	always_ff @(posedge iCLK)
	begin
		if (state == WAIT_DATA && iRdValid)
			sample <= iRdData;
	end

	// ----------------------------------------
	// outputs
	// ----------------------------------------
	assign oRdEn     = (state == POP);
	assign oReqValid = (state == REQ);
	assign oIdle     = (state == IDLE);

	// channel bit picks the half
	assign oReq.addr  = {iChannel, offset};
	assign oReq.wdata = sample;
	assign oReq.write = 1'b1;

	// four-phase rule, payload frozen until the ack
	assert property (@(posedge iCLK) disable iff (iRST)
		(oReqValid && !iRsp.ack) |=> $stable(oReq))
		else $error("ram request changed before ack");

	// fifo data only while expected
	assert property (@(posedge iCLK) disable iff (iRST)
		iRdValid |-> (state == WAIT_DATA))
		else $error("fifo read-valid outside WAIT_DATA");

endmodule

//--- fifoController.sv
module fifoController
	import capturePkg::*;
(
	input  logic    iCLK,
	input  logic    iRST,
	input  logic    iWrEn,
	input  sample_t iWrData,
	output logic    oFull,
	input  logic    iRdEn,
	output sample_t oRdData,
	output logic    oRdValid,
	output logic    oEmpty
);

	fifoAddr_t wrPtr;
	fifoAddr_t rdPtr;
	fifoAddr_t rdPtrOld;
	fifoAddr_t wrPtrNext;
	fifoAddr_t rdPtrNext;
	logic      wrAccept;
	logic      rdAccept;
	logic      nearFull;

	// ----------------------------------------
	// accept logic
	// ----------------------------------------
	// spare slots still take writes
	// only a truly full buffer drops one
	assign wrAccept = iWrEn & ((wrPtr + fifoAddr_t'(1)) != rdPtr);
	// pop ignored while empty
	assign rdAccept = iRdEn & ~oEmpty;

	assign wrPtrNext = wrAccept ? wrPtr + fifoAddr_t'(1) : wrPtr;
	assign rdPtrNext = rdAccept ? rdPtr + fifoAddr_t'(1) : rdPtr;

	// write pointer ahead by 1 .. ALMOST_FULL+1 hits read pointer
	always_comb
	begin
		nearFull = 1'b0;
		for (int n = 1; n <= ALMOST_FULL + 1; n++)
		begin
			nearFull = nearFull | ((wrPtrNext + fifoAddr_t'(n)) == rdPtrNext);
		end
	end

	// ----------------------------------------
	// pointers
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			rdPtrOld <= '0;
		end
		else
		begin
			wrPtr    <= wrPtrNext;
			rdPtr    <= rdPtrNext;
			// delayed copy, drives the memory read address
			rdPtrOld <= rdPtr;
		end
	end

	// ----------------------------------------
	// status flags
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			oFull    <= 1'b0;
			oEmpty   <= 1'b1;
			oRdValid <= 1'b0;
		end
		else
		begin
			oFull    <= nearFull;
			oEmpty   <= (wrPtrNext == rdPtrNext);
			// pointer moved last cycle, so data lands now
			oRdValid <= (rdPtr != rdPtrOld);
		end
	end

	// word at rdPtrOld comes out with oRdValid
	// two cycles after the accepted pop
	fifoMem uMem (
		.iCLK    (iCLK),
		.iWrEn   (wrAccept),
		.iWrAddr (wrPtr),
		.iWrData (iWrData),
		.iRdAddr (rdPtrOld),
		.oRdData (oRdData)
	);

	// reader must never pop an empty buffer
	assert property (@(posedge iCLK) disable iff (iRST)
		iRdEn |-> !oEmpty)
		else $error("fifo pop requested while empty");

endmodule

//--- fifoMem.sv
module fifoMem
	import capturePkg::*;
(
	input  logic      iCLK,
	input  logic      iWrEn,
	input  fifoAddr_t iWrAddr,
	input  sample_t   iWrData,
	input  fifoAddr_t iRdAddr,
	output sample_t   oRdData
);

	// sample storage, one word per FIFO slot
	sample_t mem [FIFO_DEPTH];

	// ----------------------------------------
	// write port
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iWrEn)
		begin
			mem[iWrAddr] <= iWrData;
		end
	end

	// ----------------------------------------
	// read port
	// ----------------------------------------
	// registered read, one cycle from address
	always_ff @(posedge iCLK)
	begin
		oRdData <= mem[iRdAddr];
	end

endmodule

//--- ramArbiter.sv
module ramArbiter
	import capturePkg::*;
(
	input  logic                 iCLK,
	input  logic                 iRST,
	input  logic [NUM_PEERS-1:0] iReqValid,
	input  ramReq_t              iReq [NUM_PEERS],
	output ramRsp_t              oRsp [NUM_PEERS],
	output logic                 oRamEn,
	output logic                 oRamWe,
	output ramAddr_t             oRamAddr,
	output sample_t              oRamWData,
	input  sample_t              iRamRData
);

	typedef logic [$clog2(NUM_PEERS)-1:0] peerIdx_t;

	arbState_t            state;
	// current grant, also the round-robin start point
	peerIdx_t             grant;
	peerIdx_t             pick;
	logic                 pickValid;
	logic [NUM_PEERS-1:0] ackVec;
	// last read word per peer
	sample_t              rdataHold [NUM_PEERS];

	// ----------------------------------------
	// round-robin pick
	// ----------------------------------------
	// first requester after the last grant
	always_comb
	begin
		int idx;
		pickValid = 1'b0;
		pick      = grant;
		for (int k = 1; k <= NUM_PEERS; k++)
		begin
			idx = (int'(grant) + k) % NUM_PEERS;
			if (!pickValid && iReqValid[idx])
			begin
				pickValid = 1'b1;
				pick      = peerIdx_t'(idx);
			end
		end
	end

	// ----------------------------------------
	// FSM
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state <= FREE;
			// peer 0 wins the first round
			grant <= peerIdx_t'(NUM_PEERS - 1);
		end
		else
		begin
			case (state)
				FREE:
				begin
					if (pickValid)
					begin
						grant <= pick;
						state <= ACCESS;
					end
				end
				// single RAM cycle
				ACCESS:
				begin
					state <= HOLD;
				end
				// ack high until the peer lets go
				HOLD:
				begin
					if (!iReqValid[grant])
						state <= DROP;
				end
				default:
				begin
					state <= FREE;
				end
			endcase
		end
	end

	// read data capture
	always_ff @(posedge iCLK)
	begin
		if (state == HOLD)
			rdataHold[grant] <= iRamRData;
	end

	// ----------------------------------------
	// RAM side and responses
	// ----------------------------------------
	assign oRamEn    = (state == ACCESS);
	assign oRamWe    = (state == ACCESS) && iReq[grant].write;
	assign oRamAddr  = iReq[grant].addr;
	assign oRamWData = iReq[grant].wdata;

	always_comb
	begin
		for (int p = 0; p < NUM_PEERS; p++)
		begin
			ackVec[p]     = (state == HOLD) && (grant == peerIdx_t'(p));
			oRsp[p].ack   = ackVec[p];
			// RAM output still holds the word in HOLD
			oRsp[p].rdata = ackVec[p] ? iRamRData : rdataHold[p];
		end
	end

	// granted peer keeps its request up through the RAM cycle
	assert property (@(posedge iCLK) disable iff (iRST)
		(state == ACCESS) |-> iReqValid[grant])
		else $error("granted peer dropped req before ack");

	// ack never outlives the owner's req by more than a cycle
	for (genvar g = 0; g < NUM_PEERS; g++)
	begin : gAckCheck
		assert property (@(posedge iCLK) disable iff (iRST)
			ackVec[g] |-> $past(iReqValid[g]))
			else $error("ack without a live request");
	end

endmodule

//--- sharedRam.sv
module sharedRam
	import capturePkg::*;
(
	input  logic     iCLK,
	input  logic     iEn,
	input  logic     iWe,
	input  ramAddr_t iAddr,
	input  sample_t  iWData,
	output sample_t  oRData
);

	// lower half channel 0, upper half channel 1
	sample_t mem [RAM_DEPTH];

	// ----------------------------------------
	// single port, read-first
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iEn)
		begin
			if (iWe)
				mem[iAddr] <= iWData;
			// data valid the cycle after iEn
			oRData <= mem[iAddr];
		end
	end

endmodule

//--- tbCaptureTop.sv
module tbCaptureTop
	import capturePkg::*;
();

	// polling limits in clock cycles
	localparam int WAIT_LIMIT = 200;
	localparam int IDLE_LIMIT = 4000;

	logic        iCLK;
	logic        iRST;
	logic        wrEn [2];
	sample_t     wrData [2];
	logic        oFull0;
	logic        oFull1;
	logic        oIdle0;
	logic        oIdle1;
	logic        hostReq;
	ramAddr_t    hostAddr;
	logic        hostAck;
	sample_t     hostRData;
	// background burst in flight per channel
	logic        burstBusy [2];
	// cycles with oFull high, and the count when a burst started
	int          fullCount [2];
	int          fullMark [2];
	logic [31:0] rngState [2];

	captureTop i_dut (
		.iCLK (iCLK), .iRST (iRST),
		.iWrEn0 (wrEn[0]), .iWrData0 (wrData[0]), .oFull0 (oFull0), .oIdle0 (oIdle0),
		.iWrEn1 (wrEn[1]), .iWrData1 (wrData[1]), .oFull1 (oFull1), .oIdle1 (oIdle1),
		.hostReq (hostReq), .hostAddr (hostAddr),
		.hostAck (hostAck), .hostRData (hostRData)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #2 iCLK = ~iCLK;
	end

	// full monitor, sampled on the edge
	always @(posedge iCLK)
	begin
		if (iRST)
		begin
			fullCount[0] <= 0;
			fullCount[1] <= 0;
		end
		else
		begin
			if (oFull0)
				fullCount[0] <= fullCount[0] + 1;
			if (oFull1)
				fullCount[1] <= fullCount[1] + 1;
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic fullFlag(input int ch);
		return (ch == 0) ? oFull0 : oFull1;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
			abortRun($sformatf("** Error at time %0t: %s, got %h expected %h",
				$time, what, got, want));
	endtask

	// one sample into a channel, then a random gap
	task automatic writeSample(input int ch, input sample_t value);
		int waited;
		int gap;
		waited = 0;
		// source holds off while full
		while (fullFlag(ch))
		begin
			@(posedge iCLK);
			waited++;
			if (waited > WAIT_LIMIT)
				abortRun($sformatf("timeout: oFull%0d stayed high too long", ch));
		end
		wrEn[ch]   <= 1'b1;
		wrData[ch] <= value;
		@(posedge iCLK);
		wrEn[ch]     <= 1'b0;
		rngState[ch] = xorshift(rngState[ch]);
		gap          = int'(rngState[ch] % 3);
		repeat (gap) @(posedge iCLK);
	endtask

	task automatic runBurst(input int ch, input int count, input sample_t first);
		for (int k = 0; k < count; k++)
			writeSample(ch, first + sample_t'(k));
		// extra edge so oIdle already covers the last write
		@(posedge iCLK);
		burstBusy[ch] = 1'b0;
	endtask

	task automatic startBurst(input int ch, input int count, input sample_t first);
		burstBusy[ch] = 1'b1;
		fullMark[ch]  = fullCount[ch];
		fork
			runBurst(ch, count, first);
		join_none
	endtask

	task automatic waitIdle();
		int waited;
		waited = 0;
		do
		begin
			@(posedge iCLK);
			waited++;
			if (waited > IDLE_LIMIT)
				abortRun("timeout: both channels did not become idle");
		end
		while (burstBusy[0] || burstBusy[1] || !oIdle0 || !oIdle1);
	endtask

	// ----------------------------------------
	// host read, four-phase
	// ----------------------------------------
	task automatic hostRead(input ramAddr_t addr, input sample_t want);
		int      waited;
		sample_t got;
		waited = 0;
		while (hostAck)
		begin
			@(posedge iCLK);
			waited++;
			if (waited > WAIT_LIMIT)
				abortRun("timeout: hostAck from the last read never fell");
		end
		hostAddr <= addr;
		hostReq  <= 1'b1;
		waited = 0;
		do
		begin
			@(posedge iCLK);
			waited++;
			if (waited > WAIT_LIMIT)
				abortRun($sformatf("timeout: no hostAck for read at %h", addr));
		end
		while (!hostAck);
		// rdata valid while ack high
		got = hostRData;
		hostReq <= 1'b0;
		@(posedge iCLK);
		checkValue("hostAck still high right after hostReq fell", hostAck, 1);
		waited = 0;
		while (hostAck)
		begin
			@(posedge iCLK);
			waited++;
			if (waited > WAIT_LIMIT)
				abortRun("timeout: hostAck did not fall after hostReq");
		end
		checkValue($sformatf("host read at address %h", addr), got, want);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		int          fd;
		int          cnt;
		string       line;
		string       cmd;
		logic [31:0] a1;
		logic [31:0] a2;
		logic [31:0] a3;
		iRST         = 1'b1;
		wrEn[0]      = 1'b0;
		wrEn[1]      = 1'b0;
		wrData[0]    = '0;
		wrData[1]    = '0;
		hostReq      = 1'b0;
		hostAddr     = '0;
		burstBusy[0] = 1'b0;
		burstBusy[1] = 1'b0;
		fullMark[0]  = 0;
		fullMark[1]  = 0;
		rngState[0]  = 32'd44;
		rngState[1]  = xorshift(32'd44);
		repeat (5) @(posedge iCLK);
		iRST <= 1'b0;
		@(posedge iCLK);
		// reset values
		checkValue("oFull0 after reset", oFull0, 0);
		checkValue("oFull1 after reset", oFull1, 0);
		checkValue("hostAck after reset", hostAck, 0);
		checkValue("oIdle0 after reset", oIdle0, 1);
		checkValue("oIdle1 after reset", oIdle1, 1);
		fd = $fopen("captureGolden.txt", "r");
		if (fd == 0)
			abortRun("could not open captureGolden.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;
			cnt = $sscanf(line, "%s %h %h %h", cmd, a1, a2, a3);
			case (cmd)
				"W": writeSample(int'(a1), sample_t'(a2));
				"B": startBurst(int'(a1), int'(a2), sample_t'(a3));
				"I": waitIdle();
				"F": checkValue($sformatf("oFull%0d seen high during burst", a1),
					fullCount[a1] != fullMark[a1], 1);
				"R": hostRead(ramAddr_t'(a1), sample_t'(a2));
				default: abortRun($sformatf("bad golden line (%0d fields): %s", cnt, line));
			endcase
		end
		$fclose(fd);
		$display("TEST PASS");
		$finish;
	end

endmodule
